//--- rtl/rsp_prep_cfg.svh
`ifndef RSP_PREP_CFG_SVH
`define RSP_PREP_CFG_SVH

// one real or imaginary part
`define RSP_COMP_W 16
// weight is Q2.14
`define RSP_FRAC_W 14

// apb bus widths
`define RSP_ADDR_W 8
`define RSP_DATA_W 32

// pipeline depth per stage, in cycles
`define RSP_LAT_SUB 1
`define RSP_LAT_MUL 4

// register byte offsets
`define RSP_REG_CTRL   8'h00
`define RSP_REG_OFFS   8'h04
`define RSP_REG_WGT    8'h08
`define RSP_REG_SATCNT 8'h0C

`endif

//--- rtl/rsp_sample_pkg.sv
`include "rsp_prep_cfg.svh"

package rsp_sample_pkg;

  // single signed part of a complex value
  typedef logic signed [`RSP_COMP_W-1:0] comp_t;

  // packed sample, imag high and real low
  typedef logic [2*`RSP_COMP_W-1:0] sample_t;

  // packed weight, same layout as a sample
  typedef logic [2*`RSP_COMP_W-1:0] weight_t;

  // full precision sum of products
  // two guard bits above the 32 bit product
  typedef logic signed [2*`RSP_COMP_W+1:0] prod_t;

endpackage

//--- rtl/rsp_reg_pkg.sv
`include "rsp_prep_cfg.svh"

package rsp_reg_pkg;

  // apb address and data words
  typedef logic [`RSP_ADDR_W-1:0] paddr_t;
  typedef logic [`RSP_DATA_W-1:0] pdata_t;

  // phase of the bus in the current cycle
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } apb_phase_e;

endpackage

//--- rtl/rsp_prep_ctrl.sv
`include "rsp_prep_cfg.svh"

module rsp_prep_ctrl
  import rsp_sample_pkg::*;
  import rsp_reg_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_psel,
  input  logic    i_penable,
  input  logic    i_pwrite,
  input  paddr_t  i_paddr,
  input  pdata_t  i_pwdata,
  output pdata_t  o_prdata,
  output logic    o_pready,
  output logic    o_pslverr,
  input  logic    i_sat,
  output logic    o_bypass,
  output sample_t o_offset,
  output weight_t o_weight
);

  // 1.0 + 0j in Q2.14
  localparam weight_t WGT_RST = weight_t'(1 << `RSP_FRAC_W);

  apb_phase_e state_q;
  apb_phase_e phase;
  logic       access;
  logic       addr_hit;
  logic       wr_en;
  logic       ctrl_wr;
  logic       bypass_q;
  sample_t    offset_q;
  weight_t    weight_q;
  weight_t    weight_dly [`RSP_LAT_SUB];
  pdata_t     satcnt_q;
  pdata_t     rd_mux;

  //////////////////////////////////////////////////
  // apb phase tracking
  //////////////////////////////////////////////////

  // access only counts after a proper setup cycle
  always_comb begin
    if (!i_psel) begin
      phase = IDLE;
    end else if (i_penable && (state_q == SETUP)) begin
      phase = ACCESS;
    end else begin
      phase = SETUP;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= phase;
    end
  end

  assign access = (phase == ACCESS);

  // decode, readback mux
  always_comb begin
    addr_hit = 1'b1;
    rd_mux   = '0;
    case (i_paddr)
      `RSP_REG_CTRL:   rd_mux = pdata_t'(bypass_q);
      `RSP_REG_OFFS:   rd_mux = offset_q;
      `RSP_REG_WGT:    rd_mux = weight_q;
      `RSP_REG_SATCNT: rd_mux = satcnt_q;
      default:         addr_hit = 1'b0;
    endcase
  end

  // zero wait states
  assign o_pready  = 1'b1;
  assign o_prdata  = (access && !i_pwrite) ? rd_mux : '0;
  assign o_pslverr = access && !addr_hit;
  // unmapped writes dropped
  assign wr_en     = access && i_pwrite && addr_hit;
  assign ctrl_wr   = wr_en && (i_paddr == `RSP_REG_CTRL);

  //////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bypass_q <= 1'b0;
      offset_q <= '0;
      weight_q <= WGT_RST;
    end else if (wr_en) begin
      case (i_paddr)
        `RSP_REG_CTRL: bypass_q <= i_pwdata[0];
        `RSP_REG_OFFS: offset_q <= i_pwdata;
        `RSP_REG_WGT:  weight_q <= i_pwdata;
        // satcnt is read only
        default: ;
      endcase
    end
  end

  // saturation events, cleared by any ctrl write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      satcnt_q <= '0;
    end else if (ctrl_wr) begin
      satcnt_q <= '0;
    end else if (i_sat) begin
      satcnt_q <= satcnt_q + 1'b1;
    end
  end

  // weight lags by the dc_sub depth so that a sample sees
  // offset and weight from the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `RSP_LAT_SUB; i++) begin
        weight_dly[i] <= WGT_RST;
      end
    end else begin
      weight_dly[0] <= weight_q;
      for (int i = 1; i < `RSP_LAT_SUB; i++) begin
        weight_dly[i] <= weight_dly[i-1];
      end
    end
  end

  assign o_bypass = bypass_q;
  assign o_offset = offset_q;
  assign o_weight = weight_dly[`RSP_LAT_SUB-1];

endmodule

//--- rtl/rsp_prep_dc_sub.sv
`include "rsp_prep_cfg.svh"

module rsp_prep_dc_sub
  import rsp_sample_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_valid,
  input  sample_t i_data,
  input  logic    i_bypass,
  input  sample_t i_offset,
  output logic    o_valid,
  output sample_t o_data,
  output logic    o_bypass,
  output logic    o_sat
);

  // symmetric limit, +-32767
  localparam int SAT_HI = 2 ** (`RSP_COMP_W - 1) - 1;

  comp_t                       x_re;
  comp_t                       x_im;
  comp_t                       u_re;
  comp_t                       u_im;
  logic signed [`RSP_COMP_W:0] diff_re;
  logic signed [`RSP_COMP_W:0] diff_im;
  logic                        clip_re;
  logic                        clip_im;

  function automatic comp_t clamp(input logic signed [`RSP_COMP_W:0] v);
    if (v > SAT_HI) begin
      return comp_t'(SAT_HI);
    end else if (v < -SAT_HI) begin
      return comp_t'(-SAT_HI);
    end
    return v[`RSP_COMP_W-1:0];
  endfunction

  // unpack parts
  assign x_re = i_data[`RSP_COMP_W-1:0];
  assign x_im = i_data[2*`RSP_COMP_W-1:`RSP_COMP_W];
  assign u_re = i_offset[`RSP_COMP_W-1:0];
  assign u_im = i_offset[2*`RSP_COMP_W-1:`RSP_COMP_W];

  // one extra bit, no wrap
  assign diff_re = x_re - u_re;
  assign diff_im = x_im - u_im;
  assign clip_re = (diff_re > SAT_HI) || (diff_re < -SAT_HI);
  assign clip_im = (diff_im > SAT_HI) || (diff_im < -SAT_HI);

  // control and flags
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_valid  <= 1'b0;
      o_bypass <= 1'b0;
      o_sat    <= 1'b0;
    end else begin
      o_valid  <= i_valid;
      o_bypass <= i_bypass;
      o_sat    <= i_valid && !i_bypass && (clip_re || clip_im);
    end
  end

  // payload, held between samples
  always_ff @(posedge clk) begin
    if (i_valid) begin
      if (i_bypass) begin
        o_data <= i_data;
      end else begin
        o_data <= {clamp(diff_im), clamp(diff_re)};
      end
    end
  end

endmodule

//--- rtl/rsp_prep_cmul.sv
`include "rsp_prep_cfg.svh"

module rsp_prep_cmul
  import rsp_sample_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_valid,
  input  sample_t i_data,
  input  logic    i_bypass,
  input  logic    i_sat,
  input  weight_t i_weight,
  output logic    o_valid,
  output sample_t o_data,
  output logic    o_sat
);

  // sideband stages before the output register
  localparam int DEPTH  = `RSP_LAT_MUL - 1;
  localparam int SAT_HI = 2 ** (`RSP_COMP_W - 1) - 1;

  // stage 1, x = a + jb, w = c + jd
  comp_t                           s1_a;
  comp_t                           s1_b;
  comp_t                           s1_c;
  comp_t                           s1_d;
  // stage 2
  logic signed [`RSP_COMP_W:0]     s2_sum;
  logic signed [`RSP_COMP_W:0]     s2_dif;
  logic signed [2*`RSP_COMP_W-1:0] s2_ad;
  logic signed [2*`RSP_COMP_W-1:0] s2_bc;
  // stage 3
  prod_t                           s3_gauss;
  prod_t                           s3_dm;
  prod_t                           s3_dp;
  // stage 4, comb part
  prod_t                           re_full;
  prod_t                           re_sh;
  prod_t                           im_sh;
  comp_t                           re_sat;
  comp_t                           im_sat;
  logic                            clip_re;
  logic                            clip_im;
  // sideband pipe
  logic [DEPTH-1:0]                vld_p;
  logic [DEPTH-1:0]                byp_p;
  logic [DEPTH-1:0]                sat_p;
  sample_t                         byp_data [DEPTH];

  //////////////////////////////////////////////////
  // gauss datapath
  //////////////////////////////////////////////////

  // capture operands
  always_ff @(posedge clk) begin
    s1_a <= i_data[`RSP_COMP_W-1:0];
    s1_b <= i_data[2*`RSP_COMP_W-1:`RSP_COMP_W];
    s1_c <= i_weight[`RSP_COMP_W-1:0];
    s1_d <= i_weight[2*`RSP_COMP_W-1:`RSP_COMP_W];
  end

  // a+b, c-d, plus the two cross products
  always_ff @(posedge clk) begin
    s2_sum <= s1_a + s1_b;
    s2_dif <= s1_c - s1_d;
    s2_ad  <= s1_a * s1_d;
    s2_bc  <= s1_b * s1_c;
  end

  // (a+b)(c-d) = ac - ad + bc - bd
  always_ff @(posedge clk) begin
    s3_gauss <= s2_sum * s2_dif;
    s3_dm    <= s2_ad - s2_bc;
    s3_dp    <= s2_ad + s2_bc;
  end

  // re = ac - bd, im = ad + bc
  assign re_full = s3_gauss + s3_dm;
  // drop fraction bits, truncating
  assign re_sh   = re_full >>> `RSP_FRAC_W;
  assign im_sh   = s3_dp >>> `RSP_FRAC_W;

  assign clip_re = (re_sh > SAT_HI) || (re_sh < -SAT_HI);
  assign clip_im = (im_sh > SAT_HI) || (im_sh < -SAT_HI);

  always_comb begin
    re_sat = re_sh[`RSP_COMP_W-1:0];
    if (re_sh > SAT_HI) begin
      re_sat = comp_t'(SAT_HI);
    end else if (re_sh < -SAT_HI) begin
      re_sat = comp_t'(-SAT_HI);
    end
  end

  always_comb begin
    im_sat = im_sh[`RSP_COMP_W-1:0];
    if (im_sh > SAT_HI) begin
      im_sat = comp_t'(SAT_HI);
    end else if (im_sh < -SAT_HI) begin
      im_sat = comp_t'(-SAT_HI);
    end
  end

  //////////////////////////////////////////////////
  // sideband and output
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_p   <= '0;
      byp_p   <= '0;
      sat_p   <= '0;
      o_valid <= 1'b0;
      o_sat   <= 1'b0;
    end else begin
      vld_p   <= {vld_p[DEPTH-2:0], i_valid};
      byp_p   <= {byp_p[DEPTH-2:0], i_bypass};
      sat_p   <= {sat_p[DEPTH-2:0], i_sat};
      o_valid <= vld_p[DEPTH-1];
      // upstream flag or own clipping, never in bypass
      o_sat   <= vld_p[DEPTH-1] &&
                 (sat_p[DEPTH-1] || (!byp_p[DEPTH-1] && (clip_re || clip_im)));
    end
  end

  // raw sample rides along for bypass
  always_ff @(posedge clk) begin
    byp_data[0] <= i_data;
    for (int i = 1; i < DEPTH; i++) begin
      byp_data[i] <= byp_data[i-1];
    end
    if (byp_p[DEPTH-1]) begin
      o_data <= byp_data[DEPTH-1];
    end else begin
      o_data <= {im_sat, re_sat};
    end
  end

endmodule

//--- rtl/rsp_prep_top.sv
module rsp_prep_top
  import rsp_sample_pkg::*;
  import rsp_reg_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    i_psel,
  input  logic    i_penable,
  input  logic    i_pwrite,
  input  paddr_t  i_paddr,
  input  pdata_t  i_pwdata,
  output pdata_t  o_prdata,
  output logic    o_pready,
  output logic    o_pslverr,
  input  logic    i_valid,
  input  sample_t i_data,
  output logic    o_valid,
  output sample_t o_data
);

  // config from ctrl
  logic    bypass;
  sample_t offset;
  weight_t weight;
  // dc_sub to cmul
  logic    sub_valid;
  sample_t sub_data;
  logic    sub_bypass;
  logic    sub_sat;
  // saturation pulse back to ctrl
  logic    mul_sat;

  rsp_prep_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .i_sat     (mul_sat),
    .o_bypass  (bypass),
    .o_offset  (offset),
    .o_weight  (weight)
  );

  rsp_prep_dc_sub u_dc_sub (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_valid  (i_valid),
    .i_data   (i_data),
    .i_bypass (bypass),
    .i_offset (offset),
    .o_valid  (sub_valid),
    .o_data   (sub_data),
    .o_bypass (sub_bypass),
    .o_sat    (sub_sat)
  );

  rsp_prep_cmul u_cmul (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_valid  (sub_valid),
    .i_data   (sub_data),
    .i_bypass (sub_bypass),
    .i_sat    (sub_sat),
    .i_weight (weight),
    .o_valid  (o_valid),
    .o_data   (o_data),
    .o_sat    (mul_sat)
  );

endmodule

//--- dv/rsp_prep_checker.sv
module rsp_prep_checker (
  input logic clk,
  input logic rst_n,
  input logic i_psel,
  input logic i_penable,
  input logic o_pready,
  input logic i_valid,
  input logic o_valid
);

  // no wait states on the apb side
  a_pready : assert property (@(posedge clk) disable iff (!rst_n)
    (i_psel && i_penable) |-> o_pready)
    else $error("o_pready low during an access phase");

  // stream latency, dc_sub plus cmul
  a_latency : assert property (@(posedge clk) disable iff (!rst_n)
    o_valid == $past(i_valid, 5))
    else $error("o_valid is not i_valid delayed by 5 cycles");

  a_valid_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(o_valid))
    else $error("o_valid is unknown after reset");

endmodule

//--- dv/rsp_prep_clkgen.sv
module rsp_prep_clkgen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 5
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // reset low for RST_CYCLES rising edges, released on a falling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

//--- dv/rsp_prep_tb.sv
`include "rsp_prep_cfg.svh"

module rsp_prep_tb
  import rsp_sample_pkg::*;
  import rsp_reg_pkg::*;
;

  localparam int NROWS = 6;
  // samples per row
  localparam int NSAMP = 8;
  localparam int LAT   = `RSP_LAT_SUB + `RSP_LAT_MUL;
  // per row: stream with gaps, drain, about 8 apb accesses of 3 cycles
  localparam int LIMIT = NROWS * (2 * NSAMP + LAT + 3 * 8) + 100;

  logic    clk;
  logic    rst_n;
  logic    i_psel;
  logic    i_penable;
  logic    i_pwrite;
  paddr_t  i_paddr;
  pdata_t  i_pwdata;
  pdata_t  o_prdata;
  logic    o_pready;
  logic    o_pslverr;
  logic    i_valid;
  sample_t i_data;
  logic    o_valid;
  sample_t o_data;

  integer  seed = 32'hd6da;
  int      cyc;
  string   cur_name;
  sample_t exp_q[$];
  int      due_q[$];

  ////////////////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////////////////

  string       row_name[NROWS] = '{"cplx_rand", "cplx_fixed", "sat_pos", "sat_sub",
                                   "bypass", "mode_flip"};
  bit          row_byp[NROWS]  = '{0, 0, 0, 0, 1, 0};
  // random u, w and x
  bit          row_rnd[NROWS]  = '{1, 0, 0, 0, 1, 1};
  // toggle the mode halfway through the stream
  bit          row_flip[NROWS] = '{0, 0, 0, 0, 0, 1};
  bit          row_sat[NROWS]  = '{0, 0, 1, 1, 0, 0};
  logic [31:0] row_u[NROWS]    = '{0, 32'h0010_fff0, 0, 32'h0000_7530, 0, 0};
  logic [31:0] row_w[NROWS]    = '{0, 32'h2000_c000, 32'h0000_7fff, 32'h0000_4000, 0, 0};
  logic [31:0] row_x[NROWS]    = '{0, 32'h1234_0567, 32'h7000_7000, 32'h0000_8ad0, 0, 0};

  rsp_prep_clkgen #(.PERIOD(20), .RST_CYCLES(5)) u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  rsp_prep_top u_rsp_prep_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .i_valid   (i_valid),
    .i_data    (i_data),
    .o_valid   (o_valid),
    .o_data    (o_data)
  );

  bind rsp_prep_top rsp_prep_checker u_checker (.*);

  // symmetric 16 bit limit
  function automatic longint limit(input longint v);
    if (v > 32767) begin
      return 32767;
    end else if (v < -32767) begin
      return -32767;
    end
    return v;
  endfunction

  // y = (x - u) * w, bit 32 is the clip flag
  function automatic logic [32:0] model(input bit byp, input logic [31:0] u,
                                        input logic [31:0] w, input logic [31:0] x);
    longint dr;
    longint di;
    longint pr;
    longint pi;
    bit     c;
    if (byp) begin
      return {1'b0, x};
    end
    dr = longint'($signed(x[15:0])) - longint'($signed(u[15:0]));
    di = longint'($signed(x[31:16])) - longint'($signed(u[31:16]));
    c  = (limit(dr) != dr) || (limit(di) != di);
    dr = limit(dr);
    di = limit(di);
    pr = dr * longint'($signed(w[15:0])) - di * longint'($signed(w[31:16]));
    pi = dr * longint'($signed(w[31:16])) + di * longint'($signed(w[15:0]));
    // Q2.14 back to integer, floor
    pr = pr >>> 14;
    pi = pi >>> 14;
    c  = c || (limit(pr) != pr) || (limit(pi) != pi);
    return {c, 16'(limit(pi)), 16'(limit(pr))};
  endfunction

  function automatic logic [15:0] rnd_part(input int lim);
    int v;
    v = $random(seed) % lim;
    return 16'(v);
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("sim failed");
      $fatal(1, "check failed");
    end
  endtask

  ////////////////////////////////////////////////////
  // apb master
  ////////////////////////////////////////////////////

  task automatic apb_xfer(input bit wr, input paddr_t addr, input pdata_t wdata,
                          output pdata_t rdata, output bit err);
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(negedge clk);
    i_penable = 1'b1;
    // mid low phase, before the write edge
    #5;
    rdata = o_prdata;
    err   = o_pslverr;
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_write(input paddr_t addr, input pdata_t wdata);
    pdata_t rd;
    bit     err;
    apb_xfer(1'b1, addr, wdata, rd, err);
    compare({cur_name, " write pslverr"}, 0, err);
  endtask

  task automatic apb_read_check(input paddr_t addr, input pdata_t exp, input string what);
    pdata_t rd;
    bit     err;
    apb_xfer(1'b0, addr, '0, rd, err);
    compare({cur_name, " read pslverr"}, 0, err);
    compare({cur_name, " ", what}, exp, rd);
  endtask

  // cycle count for latency and timeout
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  always @(negedge clk) begin
    if (cyc > LIMIT) begin
      $display("timeout: expected output samples never arrived in %0d cycles", LIMIT);
      $display("sim failed");
      $fatal(1, "timeout");
    end
  end

  // output monitor, in order, at the predicted cycle
  always @(negedge clk) begin
    if (rst_n && o_valid) begin
      if (exp_q.size() == 0) begin
        $display("output sample appeared while no input sample was pending");
        $display("sim failed");
        $fatal(1, "unexpected output");
      end
      compare({cur_name, " data"}, exp_q.pop_front(), o_data);
      compare({cur_name, " latency"}, due_q.pop_front(), cyc);
    end
  end

  initial begin
    pdata_t      rd;
    bit          err;
    bit          mode;
    int          sat_cnt;
    logic [31:0] u;
    logic [31:0] w;
    logic [31:0] x;
    logic [32:0] res;
    cyc       = 0;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    i_valid   = 1'b0;
    i_data    = '0;
    cur_name  = "reset";
    wait (rst_n);
    // idle, monitor flags any stray o_valid
    repeat (10) @(negedge clk);
    apb_read_check(`RSP_REG_CTRL, 32'h0, "ctrl");
    apb_read_check(`RSP_REG_OFFS, 32'h0, "offs");
    apb_read_check(`RSP_REG_WGT, 32'h0000_4000, "wgt");
    apb_read_check(`RSP_REG_SATCNT, 32'h0, "satcnt");

    cur_name = "readback";
    apb_write(`RSP_REG_OFFS, 32'h1234_5678);
    apb_write(`RSP_REG_WGT, 32'h8001_7ffe);
    apb_read_check(`RSP_REG_OFFS, 32'h1234_5678, "offs");
    apb_read_check(`RSP_REG_WGT, 32'h8001_7ffe, "wgt");

    // unmapped, error and no side effect
    cur_name = "unmapped";
    apb_xfer(1'b1, 8'h10, 32'hffff_ffff, rd, err);
    compare("unmapped write pslverr", 1, err);
    apb_xfer(1'b0, 8'h24, '0, rd, err);
    compare("unmapped read pslverr", 1, err);
    apb_read_check(`RSP_REG_CTRL, 32'h0, "ctrl");
    apb_read_check(`RSP_REG_OFFS, 32'h1234_5678, "offs");
    apb_read_check(`RSP_REG_WGT, 32'h8001_7ffe, "wgt");

    for (int r = 0; r < NROWS; r++) begin
      cur_name = row_name[r];
      if (row_rnd[r]) begin
        // small ranges keep random rows clear of clipping
        u = {rnd_part(8192), rnd_part(8192)};
        w = {rnd_part(16384), rnd_part(16384)};
      end else begin
        u = row_u[r];
        w = row_w[r];
      end
      mode = row_byp[r];
      apb_write(`RSP_REG_CTRL, {31'b0, mode});
      apb_write(`RSP_REG_OFFS, u);
      apb_write(`RSP_REG_WGT, w);
      sat_cnt = 0;
      for (int k = 0; k < NSAMP; k++) begin
        @(negedge clk);
        if (row_flip[r] && (k == NSAMP / 2)) begin
          // earlier samples still in flight keep the old mode
          i_valid = 1'b0;
          apb_write(`RSP_REG_CTRL, {31'b0, !mode});
          mode = !mode;
          @(negedge clk);
        end
        if (($random(seed) & 3) == 0) begin
          i_valid = 1'b0;
          @(negedge clk);
        end
        x       = row_rnd[r] ? {rnd_part(8192), rnd_part(8192)} : row_x[r];
        i_valid = 1'b1;
        i_data  = x;
        res     = model(mode, u, w, x);
        exp_q.push_back(res[31:0]);
        due_q.push_back(cyc + LAT);
        sat_cnt += int'(res[32]);
      end
      @(negedge clk);
      i_valid = 1'b0;
      while (exp_q.size() != 0) begin
        @(negedge clk);
      end
      apb_read_check(`RSP_REG_SATCNT, pdata_t'(sat_cnt), "satcnt");
      compare({cur_name, " sat flag"}, row_sat[r], sat_cnt != 0);
      if (row_sat[r]) begin
        apb_write(`RSP_REG_CTRL, {31'b0, mode});
        apb_read_check(`RSP_REG_SATCNT, 32'h0, "satcnt clear");
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule

//--- rsp_prep_top.f
+incdir+rtl
rtl/rsp_sample_pkg.sv
rtl/rsp_reg_pkg.sv
rtl/rsp_prep_ctrl.sv
rtl/rsp_prep_dc_sub.sv
rtl/rsp_prep_cmul.sv
rtl/rsp_prep_top.sv
dv/rsp_prep_checker.sv
dv/rsp_prep_clkgen.sv
dv/rsp_prep_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rsp_prep testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    -f rsp_prep_top.f --top-module rsp_prep_tb -o sim_rsp_prep &&
  ./obj_dir/sim_rsp_prep | tee /dev/stderr | grep -x "sim passed" > /dev/null &&
  echo "run.sh: PASS" ||
  { echo "run.sh: FAIL"; exit 1; }
